//--- gpio_top.f
verilog/gpio_pkg.sv
verilog/gpio_reg_if.sv
verilog/gpio_decoder.sv
verilog/gpio_port.sv
verilog/gpio_top.sv
testbench/gpio_props.sv
testbench/gpio_tb.sv

//--- Bender.yml
package:
  name: gpio_top

sources:
  # RTL in compile order
  - verilog/gpio_pkg.sv
  - verilog/gpio_reg_if.sv
  - verilog/gpio_decoder.sv
  - verilog/gpio_port.sv
  - verilog/gpio_top.sv

  # Simulation only
  - target: test
    files:
      - testbench/gpio_props.sv
      - testbench/gpio_tb.sv

//--- testbench/gpio_cases.txt
# Columns, hex: W byte_addr data byte_en | R byte_addr expected_word
#               P port pins | Q irq_port1 irq_port2 | N idle_cycles
R 20 0000
R 22 0000
R 24 0000
R 26 0000
R 28 0000
R 2a 0000
R 2c 0000
R 2e 0000
R 18 0000
R 1a 0000
W 20 a5ff 2
R 20 a500
W 26 ff5a 3
R 26 005a
W 1a c33c 3
R 1a c33c
W 18 7e00 2
R 18 7e00
P 2 96
N 3
R 28 0096
P 3 81
N 3
R 18 7e81
W 2a 0000 2
R 2a 0000
W 24 0100 3
P 1 01
N 5
Q 1 0
R 22 0100
W 22 0000 2
Q 0 0
W 2c 0101 3
P 2 97
N 5
Q 0 0
R 2a 0000
P 2 96
N 5
Q 0 1
R 2a 0100
P 3 00
N 5
Q 0 1
R 1c 0000
R 1e 0000
W 2a 0000 2
Q 0 0
W 0421 ffff 3
R 0420 0000
R 20 a501

//--- testbench/gpio_tb.sv
/*
 * Testbench for the GPIO block. Replays the operations listed in the
 * case file on the peripheral bus and the pins, then runs random OUT,
 * DIR and SEL write and readback pairs on all three ports.
 */

`timescale 1ns/1ps

module gpio_tb;
  import gpio_pkg::*;

  localparam int RAND_PAIRS = 32;

  logic              mclk = 1'b0;
  logic              puc_rst;
  logic              per_en;
  logic [ADDR_W-1:0] per_addr;
  logic [1:0]        per_we;
  bus_word_t         per_din;
  bus_word_t         per_dout;
  port_byte_t        p1_din;
  port_byte_t        p2_din;
  port_byte_t        p3_din;
  port_byte_t        p1_dout, p1_dout_en, p1_sel;
  port_byte_t        p2_dout, p2_dout_en, p2_sel;
  port_byte_t        p3_dout, p3_dout_en, p3_sel;
  logic              irq_port1;
  logic              irq_port2;

  // One entry per operation line of the case file
  byte         case_kind [$];
  logic [31:0] case_a [$];
  logic [31:0] case_b [$];
  logic [31:0] case_c [$];

  int          cycle_cnt   = 0;
  int          cycle_limit = 100;  // Set again once the cases are known
  logic [31:0] lcg_state   = 32'hdabc0c17;

  gpio_top gpio_top_i (
    .mclk       (mclk),
    .puc_rst    (puc_rst),
    .per_en     (per_en),
    .per_addr   (per_addr),
    .per_we     (per_we),
    .per_din    (per_din),
    .per_dout   (per_dout),
    .p1_din     (p1_din),
    .p2_din     (p2_din),
    .p3_din     (p3_din),
    .p1_dout    (p1_dout),
    .p1_dout_en (p1_dout_en),
    .p1_sel     (p1_sel),
    .p2_dout    (p2_dout),
    .p2_dout_en (p2_dout_en),
    .p2_sel     (p2_sel),
    .p3_dout    (p3_dout),
    .p3_dout_en (p3_dout_en),
    .p3_sel     (p3_sel),
    .irq_port1  (irq_port1),
    .irq_port2  (irq_port2)
  );

  always #50 mclk = ~mclk;  // 100 ns period

  always @(posedge mclk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit)
      abort_run($sformatf("Timeout, test still running after %0d cycles", cycle_limit));
  end

  // A bound assertion failure ends the run at once
  always @(gpio_top_i.props_i.fail_cnt) begin
    if (gpio_top_i.props_i.fail_cnt != 0)
      abort_run("A bound assertion on gpio_top failed");
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // One access cycle at a byte address, then the bus goes idle
  task automatic bus_cycle(input logic [31:0] byte_addr, input logic [1:0] we,
                           input bus_word_t data, output bus_word_t rdata);
    @(posedge mclk);
    #5;
    per_en   = 1'b1;
    per_addr = byte_addr[ADDR_W:1];
    per_we   = we;
    per_din  = data;
    #40;
    rdata = per_dout;  // Settled well before the next edge
    @(posedge mclk);
    #5;
    per_en   = 1'b0;
    per_addr = '0;
    per_we   = '0;
    per_din  = '0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge mclk);
      #5;
    end
  endtask

  task automatic drive_pins(input int port, input port_byte_t value);
    case (port)
      1: p1_din = value;
      2: p2_din = value;
      3: p3_din = value;
      default: abort_run($sformatf("Case file names port %0d, which does not exist", port));
    endcase
  endtask

  // kind: 0 OUT, 1 DIR, 2 SEL
  function automatic logic [DEC_WD-1:0] reg_offset(input int port, input int kind);
    case (port)
      1:       return (kind == 0) ? P1OUT_OFS : (kind == 1) ? P1DIR_OFS : P1SEL_OFS;
      2:       return (kind == 0) ? P2OUT_OFS : (kind == 1) ? P2DIR_OFS : P2SEL_OFS;
      default: return (kind == 0) ? P3OUT_OFS : (kind == 1) ? P3DIR_OFS : P3SEL_OFS;
    endcase
  endfunction

  function automatic port_byte_t pin_value(input int port, input int kind);
    case (port)
      1:       return (kind == 0) ? p1_dout : (kind == 1) ? p1_dout_en : p1_sel;
      2:       return (kind == 0) ? p2_dout : (kind == 1) ? p2_dout_en : p2_sel;
      default: return (kind == 0) ? p3_dout : (kind == 1) ? p3_dout_en : p3_sel;
    endcase
  endfunction

  // Single-lane write, the disabled lane carries the inverted byte
  task automatic write_lane(input int port, input int kind, input port_byte_t val);
    logic [DEC_WD-1:0] ofs;
    bus_word_t         rdata;
    ofs = reg_offset(port, kind);
    bus_cycle(ofs, ofs[0] ? 2'b10 : 2'b01, ofs[0] ? {val, ~val} : {~val, val}, rdata);
  endtask

  // ----------------------------------------
  // Case file
  // ----------------------------------------
  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    fd = $fopen("testbench/gpio_cases.txt", "r");
    if (fd == 0)
      abort_run("Cannot open the case file testbench/gpio_cases.txt");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line[0] != "#") begin  // Skip blank and comment lines
        a = '0;
        b = '0;
        c = '0;
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
        case_kind.push_back(line[0]);
        case_a.push_back(a);
        case_b.push_back(b);
        case_c.push_back(c);
      end
    end
    $fclose(fd);
  endtask

  task automatic run_cases();
    bus_word_t rdata;
    for (int i = 0; i < case_kind.size(); i++) begin
      case (case_kind[i])
        "W": bus_cycle(case_a[i], case_c[i][1:0], case_b[i][DATA_W-1:0], rdata);
        "R": begin
          bus_cycle(case_a[i], 2'b00, '0, rdata);
          check_value($sformatf("per_dout at 0x%0h", case_a[i]), rdata, case_b[i]);
        end
        "P": drive_pins(case_a[i], case_b[i][BYTE_W-1:0]);
        "Q": begin
          check_value("irq_port1", irq_port1, case_a[i]);
          check_value("irq_port2", irq_port2, case_b[i]);
        end
        "N": idle_cycles(case_a[i]);
        default: abort_run($sformatf("Unknown line kind %c in the case file", case_kind[i]));
      endcase
    end
  endtask

  task automatic random_readback(input int pairs);
    int                port;
    int                kind;
    port_byte_t        val;
    logic [DEC_WD-1:0] ofs;
    bus_word_t         rdata;
    port_byte_t        shadow [1:3][3];  // Expected OUT, DIR and SEL per port
    string             suffix [3] = '{"dout", "dout_en", "sel"};
    // Known start state for all nine registers
    for (int p = 1; p <= 3; p++) begin
      for (int k = 0; k < 3; k++) begin
        lcg_state = lcg_next(lcg_state);
        shadow[p][k] = lcg_state[15:8];
        write_lane(p, k, shadow[p][k]);
      end
    end
    for (int i = 0; i < pairs; i++) begin
      lcg_state = lcg_next(lcg_state);
      port  = lcg_state[31:24] % 3 + 1;
      kind  = lcg_state[23:16] % 3;
      val   = lcg_state[15:8];
      ofs   = reg_offset(port, kind);
      shadow[port][kind] = val;
      write_lane(port, kind, val);
      bus_cycle(ofs, 2'b00, '0, rdata);
      check_value($sformatf("per_dout at 0x%0h", ofs), ofs[0] ? rdata[15:8] : rdata[7:0], val);
      // Every pin group, so a write leaking into the other lane shows up
      for (int p = 1; p <= 3; p++) begin
        for (int k = 0; k < 3; k++)
          check_value($sformatf("p%0d_%s", p, suffix[k]), pin_value(p, k), shadow[p][k]);
      end
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    puc_rst  = 1'b1;
    per_en   = 1'b0;
    per_addr = '0;
    per_we   = '0;
    per_din  = '0;
    p1_din   = '0;
    p2_din   = '0;
    p3_din   = '0;
    load_cases();
    cycle_limit = (case_kind.size() + RAND_PAIRS) * 8 + 100;

    repeat (4) @(posedge mclk);
    #5;
    puc_rst = 1'b0;

    check_value("p1_dout/p1_dout_en/p1_sel", {p1_dout, p1_dout_en, p1_sel}, 0);
    check_value("p2_dout/p2_dout_en/p2_sel", {p2_dout, p2_dout_en, p2_sel}, 0);
    check_value("p3_dout/p3_dout_en/p3_sel", {p3_dout, p3_dout_en, p3_sel}, 0);
    check_value("irq_port1/irq_port2", {irq_port1, irq_port2}, 0);

    run_cases();
    random_readback(RAND_PAIRS);

    if (gpio_top_i.props_i.fail_cnt == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      abort_run($sformatf("Bound assertions failed %0d times", gpio_top_i.props_i.fail_cnt));
    end
  end

endmodule

//--- testbench/gpio_props.sv
/*
 * Concurrent checks on the GPIO top level, bound into every gpio_top.
 * Idle bus read data, interrupt lines after reset and pin hold without
 * a write. Failures are counted for the testbench.
 */

`timescale 1ns/1ps

module gpio_props (
  input logic                 mclk,
  input logic                 puc_rst,
  input logic                 per_en,
  input logic [1:0]           per_we,
  input gpio_pkg::bus_word_t  per_dout,
  input gpio_pkg::port_byte_t p1_dout,
  input gpio_pkg::port_byte_t p1_dout_en,
  input gpio_pkg::port_byte_t p1_sel,
  input gpio_pkg::port_byte_t p2_dout,
  input gpio_pkg::port_byte_t p2_dout_en,
  input gpio_pkg::port_byte_t p2_sel,
  input gpio_pkg::port_byte_t p3_dout,
  input gpio_pkg::port_byte_t p3_dout_en,
  input gpio_pkg::port_byte_t p3_sel,
  input logic                 irq_port1,
  input logic                 irq_port2
);
  import gpio_pkg::*;

  int unsigned fail_cnt = 0;  // Read by the testbench at the end

  logic [9*BYTE_W-1:0] pins;

  assign pins = {p1_dout, p1_dout_en, p1_sel, p2_dout, p2_dout_en, p2_sel,
                 p3_dout, p3_dout_en, p3_sel};

  // ----------------------------------------
  // Properties
  // ----------------------------------------
  dout_idle_zero: assert property (@(posedge mclk) disable iff (puc_rst)
    !per_en |-> per_dout == '0)
    else begin
      fail_cnt++;
      $error("per_dout is not zero while per_en is low");
    end

  irq_low_after_reset: assert property (@(posedge mclk)
    $fell(puc_rst) |-> !irq_port1 && !irq_port2)
    else begin
      fail_cnt++;
      $error("Interrupt line high in the first cycle after reset");
    end

  // Pins only move on the edge that ends a write access
  pins_hold: assert property (@(posedge mclk) disable iff (puc_rst)
    !(per_en && per_we != 2'b00) |=> $stable(pins))
    else begin
      fail_cnt++;
      $error("Pin output changed without a write access");
    end

endmodule

bind gpio_top gpio_props props_i (
  .mclk       (mclk),
  .puc_rst    (puc_rst),
  .per_en     (per_en),
  .per_we     (per_we),
  .per_dout   (per_dout),
  .p1_dout    (p1_dout),
  .p1_dout_en (p1_dout_en),
  .p1_sel     (p1_sel),
  .p2_dout    (p2_dout),
  .p2_dout_en (p2_dout_en),
  .p2_sel     (p2_sel),
  .p3_dout    (p3_dout),
  .p3_dout_en (p3_dout_en),
  .p3_sel     (p3_sel),
  .irq_port1  (irq_port1),
  .irq_port2  (irq_port2)
);

//--- verilog/gpio_top.sv
/*
 * GPIO block top level. Plain peripheral bus and pin ports; one decoder
 * feeds three port banks, of which ports 1 and 2 carry interrupts.
 */

`timescale 1ns/1ps

module gpio_top #(
  parameter logic [gpio_pkg::ADDR_W-1:0] BASE_ADDR = '0
) (
  input  logic                        mclk,
  input  logic                        puc_rst,
  // Peripheral bus
  input  logic                        per_en,
  input  logic [gpio_pkg::ADDR_W-1:0] per_addr,
  input  logic [1:0]                  per_we,
  input  gpio_pkg::bus_word_t         per_din,
  output gpio_pkg::bus_word_t         per_dout,
  // Pins
  input  gpio_pkg::port_byte_t        p1_din,
  input  gpio_pkg::port_byte_t        p2_din,
  input  gpio_pkg::port_byte_t        p3_din,
  output gpio_pkg::port_byte_t        p1_dout,
  output gpio_pkg::port_byte_t        p1_dout_en,
  output gpio_pkg::port_byte_t        p1_sel,
  output gpio_pkg::port_byte_t        p2_dout,
  output gpio_pkg::port_byte_t        p2_dout_en,
  output gpio_pkg::port_byte_t        p2_sel,
  output gpio_pkg::port_byte_t        p3_dout,
  output gpio_pkg::port_byte_t        p3_dout_en,
  output gpio_pkg::port_byte_t        p3_sel,
  output logic                        irq_port1,
  output logic                        irq_port2
);

  gpio_reg_if p1_if ();
  gpio_reg_if p2_if ();
  gpio_reg_if p3_if ();

  gpio_decoder #(
    .BASE_ADDR (BASE_ADDR)
  ) decoder_i (
    .per_en   (per_en),
    .per_addr (per_addr),
    .per_we   (per_we),
    .per_din  (per_din),
    .per_dout (per_dout),
    .p1       (p1_if.ctrl),
    .p2       (p2_if.ctrl),
    .p3       (p3_if.ctrl)
  );

  // ----------------------------------------
  // Port banks
  // ----------------------------------------
  gpio_port #(.IRQ_EN(1'b1)) port1_i (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .din     (p1_din),
    .dout    (p1_dout),
    .dout_en (p1_dout_en),
    .sel     (p1_sel),
    .irq     (irq_port1),
    .bus     (p1_if.bank)
  );

  gpio_port #(.IRQ_EN(1'b1)) port2_i (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .din     (p2_din),
    .dout    (p2_dout),
    .dout_en (p2_dout_en),
    .sel     (p2_sel),
    .irq     (irq_port2),
    .bus     (p2_if.bank)
  );

  // Port 3 irq stays low, left open
  gpio_port #(.IRQ_EN(1'b0)) port3_i (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .din     (p3_din),
    .dout    (p3_dout),
    .dout_en (p3_dout_en),
    .sel     (p3_sel),
    .irq     (),
    .bus     (p3_if.bank)
  );

endmodule

//--- verilog/gpio_port.sv
/*
 * One 8-bit GPIO port bank. Synchronizes the pins into IN, holds OUT,
 * DIR and SEL, and with IRQ_EN set adds the edge-triggered interrupt
 * group IFG, IES and IE with a single interrupt line.
 */

`timescale 1ns/1ps

module gpio_port #(
  parameter bit IRQ_EN = 1'b1
) (
  input  logic                 mclk,
  input  logic                 puc_rst,
  input  gpio_pkg::port_byte_t din,
  output gpio_pkg::port_byte_t dout,
  output gpio_pkg::port_byte_t dout_en,
  output gpio_pkg::port_byte_t sel,
  output logic                 irq,
  gpio_reg_if.bank             bus
);
  import gpio_pkg::*;

  localparam int NREG = 2 ** $bits(gpio_reg_e);

  // Byte for register r, taken from the lane that addresses it
  function automatic port_byte_t lane_byte(input gpio_reg_e r, input gpio_reg_e hi,
                                           input bus_word_t w);
    return (hi == r) ? w[DATA_W-1:BYTE_W] : w[BYTE_W-1:0];
  endfunction

  port_byte_t in_meta;
  port_byte_t in_q;     // IN register
  port_byte_t out_q;
  port_byte_t dir_q;
  port_byte_t sel_q;
  port_byte_t ifg_q;
  port_byte_t ies_q;
  port_byte_t ie_q;

  logic [NREG-1:0] reg_we;
  port_byte_t      reg_val [NREG];

  // ----------------------------------------
  // Pin synchronizer
  // ----------------------------------------
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      in_meta <= '0;
      in_q    <= '0;
    end else begin
      in_meta <= din;
      in_q    <= in_meta;
    end
  end

  // Per-register write strobes, bit 0 is the idle selector
  always_comb begin
    reg_we = '0;
    if (bus.wr[0]) reg_we[bus.lo_reg] = 1'b1;
    if (bus.wr[1]) reg_we[bus.hi_reg] = 1'b1;
  end

  // ----------------------------------------
  // OUT, DIR and SEL
  // ----------------------------------------
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      out_q <= '0;
      dir_q <= '0;
      sel_q <= '0;
    end else begin
      if (reg_we[REG_OUT]) out_q <= lane_byte(REG_OUT, bus.hi_reg, bus.wdata);
      if (reg_we[REG_DIR]) dir_q <= lane_byte(REG_DIR, bus.hi_reg, bus.wdata);
      if (reg_we[REG_SEL]) sel_q <= lane_byte(REG_SEL, bus.hi_reg, bus.wdata);
    end
  end

  assign dout    = out_q;
  assign dout_en = dir_q;
  assign sel     = sel_q;

  // ----------------------------------------
  // Interrupt group
  // ----------------------------------------
  if (IRQ_EN) begin : g_irq
    port_byte_t in_dly;
    port_byte_t rise;
    port_byte_t fall;
    port_byte_t ifg_set;

    assign rise    = in_q & ~in_dly;
    assign fall    = ~in_q & in_dly;
    assign ifg_set = (ies_q & fall) | (~ies_q & rise);  // IES=1 selects falling

    always_ff @(posedge mclk or posedge puc_rst) begin
      if (puc_rst) begin
        in_dly <= '0;
        ies_q  <= '0;
        ie_q   <= '0;
        ifg_q  <= '0;
      end else begin
        in_dly <= in_q;
        if (reg_we[REG_IES]) ies_q <= lane_byte(REG_IES, bus.hi_reg, bus.wdata);
        if (reg_we[REG_IE])  ie_q  <= lane_byte(REG_IE, bus.hi_reg, bus.wdata);
        // New edges win over a software clear
        if (reg_we[REG_IFG]) ifg_q <= lane_byte(REG_IFG, bus.hi_reg, bus.wdata) | ifg_set;
        else                 ifg_q <= ifg_q | ifg_set;
      end
    end

    assign irq = |(ie_q & ifg_q);
  end else begin : g_no_irq
    assign ifg_q = '0;
    assign ies_q = '0;
    assign ie_q  = '0;
    assign irq   = 1'b0;
  end

  // ----------------------------------------
  // Read back
  // ----------------------------------------
  always_comb begin
    reg_val          = '{default: '0};
    reg_val[REG_IN]  = in_q;
    reg_val[REG_OUT] = out_q;
    reg_val[REG_DIR] = dir_q;
    reg_val[REG_IFG] = ifg_q;
    reg_val[REG_IES] = ies_q;
    reg_val[REG_IE]  = ie_q;
    reg_val[REG_SEL] = sel_q;
  end

  assign bus.rdata = bus.rd ? {reg_val[bus.hi_reg], reg_val[bus.lo_reg]} : '0;

endmodule

//--- verilog/gpio_decoder.sv
/*
 * Peripheral bus decoder for the GPIO block. Matches the word address
 * against the block base, maps both byte lanes to a port register and
 * routes the access to the owning port bank. Read data is an OR merge.
 */

`timescale 1ns/1ps

module gpio_decoder #(
  parameter logic [gpio_pkg::ADDR_W-1:0] BASE_ADDR = '0
) (
  input  logic                          per_en,
  input  logic [gpio_pkg::ADDR_W-1:0]   per_addr,
  input  logic [1:0]                    per_we,
  input  gpio_pkg::bus_word_t           per_din,
  output gpio_pkg::bus_word_t           per_dout,
  gpio_reg_if.ctrl                      p1,
  gpio_reg_if.ctrl                      p2,
  gpio_reg_if.ctrl                      p3
);
  import gpio_pkg::*;

  localparam int WORD_BITS = DEC_WD - 1;  // Word offset bits

  // Decoded byte lane: owning port (0 for none) and register
  typedef struct packed {
    logic [1:0] port;
    gpio_reg_e  rg;
  } lane_t;

  localparam lane_t LANE_IDLE = '{port: 2'd0, rg: REG_NONE};

  function automatic lane_t decode_ofs(input logic [DEC_WD-1:0] ofs);
    lane_t d;
    d = LANE_IDLE;
    case (ofs)
      P1IN_OFS:  d = '{port: 2'd1, rg: REG_IN};
      P1OUT_OFS: d = '{port: 2'd1, rg: REG_OUT};
      P1DIR_OFS: d = '{port: 2'd1, rg: REG_DIR};
      P1IFG_OFS: d = '{port: 2'd1, rg: REG_IFG};
      P1IES_OFS: d = '{port: 2'd1, rg: REG_IES};
      P1IE_OFS:  d = '{port: 2'd1, rg: REG_IE};
      P1SEL_OFS: d = '{port: 2'd1, rg: REG_SEL};
      P2IN_OFS:  d = '{port: 2'd2, rg: REG_IN};
      P2OUT_OFS: d = '{port: 2'd2, rg: REG_OUT};
      P2DIR_OFS: d = '{port: 2'd2, rg: REG_DIR};
      P2IFG_OFS: d = '{port: 2'd2, rg: REG_IFG};
      P2IES_OFS: d = '{port: 2'd2, rg: REG_IES};
      P2IE_OFS:  d = '{port: 2'd2, rg: REG_IE};
      P2SEL_OFS: d = '{port: 2'd2, rg: REG_SEL};
      P3IN_OFS:  d = '{port: 2'd3, rg: REG_IN};
      P3OUT_OFS: d = '{port: 2'd3, rg: REG_OUT};
      P3DIR_OFS: d = '{port: 2'd3, rg: REG_DIR};
      P3SEL_OFS: d = '{port: 2'd3, rg: REG_SEL};
      default:   d = LANE_IDLE;  // Hole in the map
    endcase
    return d;
  endfunction

  // Lane register as seen by port n
  function automatic gpio_reg_e lane_reg(input lane_t d, input logic [1:0] n);
    return (d.port == n) ? d.rg : REG_NONE;
  endfunction

  // ----------------------------------------
  // Block select and lane decode
  // ----------------------------------------
  logic              reg_sel;
  logic [DEC_WD-1:0] lo_ofs;
  logic [DEC_WD-1:0] hi_ofs;
  lane_t             lo_dec;
  lane_t             hi_dec;
  logic [3:1]        hit;      // Port owning the addressed word
  logic              rd_acc;

  assign reg_sel = per_en &&
                   (per_addr[ADDR_W-1:WORD_BITS] == BASE_ADDR[ADDR_W-1:WORD_BITS]);
  assign lo_ofs  = {per_addr[WORD_BITS-1:0], 1'b0};  // Even byte on low lane
  assign hi_ofs  = {per_addr[WORD_BITS-1:0], 1'b1};

  assign lo_dec = reg_sel ? decode_ofs(lo_ofs) : LANE_IDLE;
  assign hi_dec = reg_sel ? decode_ofs(hi_ofs) : LANE_IDLE;

  assign hit[1] = (lo_dec.port == 2'd1) || (hi_dec.port == 2'd1);
  assign hit[2] = (lo_dec.port == 2'd2) || (hi_dec.port == 2'd2);
  assign hit[3] = (lo_dec.port == 2'd3) || (hi_dec.port == 2'd3);

  assign rd_acc = ~|per_we;  // No byte enable means read

  // ----------------------------------------
  // Fan out to the port banks
  // ----------------------------------------
  assign p1.lo_reg = lane_reg(lo_dec, 2'd1);
  assign p1.hi_reg = lane_reg(hi_dec, 2'd1);
  assign p1.wr     = per_we & {2{hit[1]}};
  assign p1.rd     = rd_acc & hit[1];
  assign p1.wdata  = per_din;

  assign p2.lo_reg = lane_reg(lo_dec, 2'd2);
  assign p2.hi_reg = lane_reg(hi_dec, 2'd2);
  assign p2.wr     = per_we & {2{hit[2]}};
  assign p2.rd     = rd_acc & hit[2];
  assign p2.wdata  = per_din;

  assign p3.lo_reg = lane_reg(lo_dec, 2'd3);
  assign p3.hi_reg = lane_reg(hi_dec, 2'd3);
  assign p3.wr     = per_we & {2{hit[3]}};
  assign p3.rd     = rd_acc & hit[3];
  assign p3.wdata  = per_din;

  // Banks return zero when not read
  assign per_dout = p1.rdata | p2.rdata | p3.rdata;

endmodule

//--- verilog/gpio_reg_if.sv
/*
 * Register access channel between the address decoder and one port bank.
 * The decoder drives lane selects, strobes and write data; the bank
 * answers with read data.
 */

`timescale 1ns/1ps

interface gpio_reg_if;
  import gpio_pkg::*;

  gpio_reg_e  lo_reg;  // Register on bits 7:0
  gpio_reg_e  hi_reg;  // Register on bits 15:8
  logic [1:0] wr;      // Byte write enables for this bank
  logic       rd;
  bus_word_t  wdata;
  bus_word_t  rdata;   // Zero unless rd

  // Decoder side
  modport ctrl (
    output lo_reg, hi_reg, wr, rd, wdata,
    input  rdata
  );

  // Port bank side
  modport bank (
    input  lo_reg, hi_reg, wr, rd, wdata,
    output rdata
  );

endinterface

//--- verilog/gpio_pkg.sv
/*
 * Shared definitions for the GPIO block: bus and port widths, the
 * register selector passed from the decoder to each port bank, and
 * the byte offset map of all port registers.
 */

package gpio_pkg;

  // Bus geometry
  localparam int ADDR_W = 14;  // Word address
  localparam int DATA_W = 16;
  localparam int BYTE_W = 8;
  localparam int DEC_WD = 6;   // Byte offset bits inside the block

  typedef logic [BYTE_W-1:0] port_byte_t;
  typedef logic [DATA_W-1:0] bus_word_t;

  // Register inside one port bank
  typedef enum logic [2:0] {
    REG_NONE = 3'd0,
    REG_IN   = 3'd1,
    REG_OUT  = 3'd2,
    REG_DIR  = 3'd3,
    REG_IFG  = 3'd4,
    REG_IES  = 3'd5,
    REG_IE   = 3'd6,
    REG_SEL  = 3'd7
  } gpio_reg_e;

  // ----------------------------------------
  // Byte offsets
  // ----------------------------------------
  localparam logic [DEC_WD-1:0] P1IN_OFS  = 6'h20;  // Port 1
  localparam logic [DEC_WD-1:0] P1OUT_OFS = 6'h21;
  localparam logic [DEC_WD-1:0] P1DIR_OFS = 6'h22;
  localparam logic [DEC_WD-1:0] P1IFG_OFS = 6'h23;
  localparam logic [DEC_WD-1:0] P1IES_OFS = 6'h24;
  localparam logic [DEC_WD-1:0] P1IE_OFS  = 6'h25;
  localparam logic [DEC_WD-1:0] P1SEL_OFS = 6'h26;
  localparam logic [DEC_WD-1:0] P2IN_OFS  = 6'h28;  // Port 2
  localparam logic [DEC_WD-1:0] P2OUT_OFS = 6'h29;
  localparam logic [DEC_WD-1:0] P2DIR_OFS = 6'h2A;
  localparam logic [DEC_WD-1:0] P2IFG_OFS = 6'h2B;
  localparam logic [DEC_WD-1:0] P2IES_OFS = 6'h2C;
  localparam logic [DEC_WD-1:0] P2IE_OFS  = 6'h2D;
  localparam logic [DEC_WD-1:0] P2SEL_OFS = 6'h2E;
  localparam logic [DEC_WD-1:0] P3IN_OFS  = 6'h18;  // Port 3, no interrupts
  localparam logic [DEC_WD-1:0] P3OUT_OFS = 6'h19;
  localparam logic [DEC_WD-1:0] P3DIR_OFS = 6'h1A;
  localparam logic [DEC_WD-1:0] P3SEL_OFS = 6'h1B;

endpackage
